// ==== bp_pkg.sv ====
// branch predictor shared widths, branch kind codes and counter constants
package bp_pkg;

    // word address width for pc and next pc
    localparam int PC_W = 30;

    // branch kind encoding
    localparam int KIND_W = 3;

    localparam logic [KIND_W-1:0] KIND_NOT_JUMP = 3'd0;
    localparam logic [KIND_W-1:0] KIND_DIRECT   = 3'd1;
    localparam logic [KIND_W-1:0] KIND_CALL     = 3'd2;
    localparam logic [KIND_W-1:0] KIND_RET      = 3'd3;
    localparam logic [KIND_W-1:0] KIND_INDIRECT = 3'd4;
    localparam logic [KIND_W-1:0] KIND_OTHER    = 3'd5;

    // direction counters
    localparam int CNT_W = 2;

    // weakly not-taken
    localparam logic [CNT_W-1:0] CNT_INIT = 2'd1;

endpackage

// ==== ex_buffer.sv ====
// execute-side record queue that pairs resolved branches into one update per fetch packet
`timescale 1ns/1ps

module ex_buffer #(
    parameter int DEPTH = 4
) (
    input  logic                      clk,
    input  logic                      rstn,
    input  logic                      single,
    input  logic                      stall,
    input  logic                      taken_pdc_0,
    input  logic [bp_pkg::KIND_W-1:0] kind_pdc_0,
    input  logic [bp_pkg::PC_W-1:0]   npc_pdc_0,
    input  logic                      taken_ex_0,
    input  logic [bp_pkg::KIND_W-1:0] kind_ex_0,
    input  logic [bp_pkg::PC_W-1:0]   npc_ex_0,
    input  logic [bp_pkg::PC_W-1:0]   pc_ex_0,
    input  logic                      taken_pdc_1,
    input  logic [bp_pkg::KIND_W-1:0] kind_pdc_1,
    input  logic [bp_pkg::PC_W-1:0]   npc_pdc_1,
    input  logic                      taken_ex_1,
    input  logic [bp_pkg::KIND_W-1:0] kind_ex_1,
    input  logic [bp_pkg::PC_W-1:0]   npc_ex_1,
    input  logic [bp_pkg::PC_W-1:0]   pc_ex_1,
    output logic                      update_en,
    output logic [bp_pkg::PC_W-1:0]   upd_pc,
    output logic                      upd_taken_pdc,
    output logic [bp_pkg::KIND_W-1:0] upd_kind_pdc,
    output logic [bp_pkg::PC_W-1:0]   upd_npc_pdc,
    output logic                      upd_taken_ex,
    output logic [bp_pkg::KIND_W-1:0] upd_kind_ex,
    output logic [bp_pkg::PC_W-1:0]   upd_npc_ex
);
    import bp_pkg::*;

    localparam int PTR_W    = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_BITS = $clog2(DEPTH + 1);

    // one array per record field
    logic              q_taken_pdc [DEPTH];
    logic [KIND_W-1:0] q_kind_pdc  [DEPTH];
    logic [PC_W-1:0]   q_npc_pdc   [DEPTH];
    logic              q_taken_ex  [DEPTH];
    logic [KIND_W-1:0] q_kind_ex   [DEPTH];
    logic [PC_W-1:0]   q_npc_ex    [DEPTH];
    logic [PC_W-1:0]   q_pc        [DEPTH];

    logic [PTR_W-1:0]    head;
    logic [CNT_BITS-1:0] count;
    logic [PTR_W-1:0]    second;
    logic [PTR_W-1:0]    tail;
    logic [PTR_W-1:0]    tail_1;
    logic                head_odd;
    logic [1:0]          n_push;
    logic [1:0]          n_pop;

    function automatic logic [PTR_W-1:0] wrap_add(input logic [PTR_W-1:0] base,
                                                  input int unsigned off);
        int unsigned sum;
        sum = base + off;
        if (sum >= DEPTH) begin
            sum = sum - DEPTH;
        end
        return PTR_W'(sum);
    endfunction

    // first jump kind found in either record wins
    function automatic logic [KIND_W-1:0] merge_kind(input logic [KIND_W-1:0] a,
                                                     input logic [KIND_W-1:0] b);
        if (a == KIND_DIRECT || b == KIND_DIRECT) return KIND_DIRECT;
        if (a == KIND_CALL || b == KIND_CALL) return KIND_CALL;
        if (a == KIND_RET || b == KIND_RET) return KIND_RET;
        if (a == KIND_INDIRECT || b == KIND_INDIRECT) return KIND_INDIRECT;
        if (a == KIND_OTHER || b == KIND_OTHER) return KIND_OTHER;
        return KIND_NOT_JUMP;
    endfunction

    assign second   = wrap_add(head, 1);
    assign tail     = wrap_add(head, count);
    assign tail_1   = wrap_add(tail, 1);
    assign head_odd = q_pc[head][0];

    // slot 1 head is a packet alone, slot 0 head needs its partner
    assign update_en = (count != '0) && (head_odd || count >= CNT_BITS'(2));

    assign n_push = stall ? 2'd0 : (single ? 2'd1 : 2'd2);
    assign n_pop  = !update_en ? 2'd0 : (head_odd ? 2'd1 : 2'd2);

    always_comb begin
        upd_pc        = q_pc[head];
        upd_taken_pdc = q_taken_pdc[head];
        upd_kind_pdc  = q_kind_pdc[head];
        upd_npc_pdc   = q_npc_pdc[head];
        if (head_odd) begin
            upd_taken_ex = q_taken_ex[head];
            upd_kind_ex  = q_kind_ex[head];
            upd_npc_ex   = q_npc_ex[head];
        end else begin
            upd_taken_ex = q_taken_ex[head] | q_taken_ex[second];
            upd_kind_ex  = merge_kind(q_kind_ex[head], q_kind_ex[second]);
            upd_npc_ex   = q_taken_ex[head] ? q_npc_ex[head] : q_npc_ex[second];
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            head  <= '0;
            count <= '0;
        end else begin
            head  <= wrap_add(head, n_pop);
            count <= CNT_BITS'(count + n_push - n_pop);
        end
    end

    // slot 0 goes first, slot 1 behind it
    always_ff @(posedge clk) begin
        if (!stall) begin
            q_taken_pdc[tail] <= taken_pdc_0;
            q_kind_pdc[tail]  <= kind_pdc_0;
            q_npc_pdc[tail]   <= npc_pdc_0;
            q_taken_ex[tail]  <= taken_ex_0;
            q_kind_ex[tail]   <= kind_ex_0;
            q_npc_ex[tail]    <= npc_ex_0;
            q_pc[tail]        <= pc_ex_0;
            if (!single) begin
                q_taken_pdc[tail_1] <= taken_pdc_1;
                q_kind_pdc[tail_1]  <= kind_pdc_1;
                q_npc_pdc[tail_1]   <= npc_pdc_1;
                q_taken_ex[tail_1]  <= taken_ex_1;
                q_kind_ex[tail_1]   <= kind_ex_1;
                q_npc_ex[tail_1]    <= npc_ex_1;
                q_pc[tail_1]        <= pc_ex_1;
            end
        end
    end

    // producer must leave room for its pushes
    assert property (@(posedge clk) disable iff (!rstn)
        int'(count) + int'(n_push) - int'(n_pop) <= DEPTH)
        else $error("ex_buffer overflow");

    // a paired slot 0 head is followed by the slot 1 word of the same packet
    assert property (@(posedge clk) disable iff (!rstn)
        update_en && !head_odd |-> q_pc[second] == {q_pc[head][PC_W-1:1], 1'b1})
        else $error("ex_buffer slot 0 head without its partner");

endmodule

// ==== bp_resolve.sv ====
// packet mispredict check and redirect pc generation
`timescale 1ns/1ps

module bp_resolve (
    input  logic                    update_en,
    input  logic [bp_pkg::PC_W-1:0] upd_pc,
    input  logic                    upd_taken_pdc,
    input  logic [bp_pkg::PC_W-1:0] upd_npc_pdc,
    input  logic                    upd_taken_ex,
    input  logic [bp_pkg::PC_W-1:0] upd_npc_ex,
    output logic                    mispredict,
    output logic [bp_pkg::PC_W-1:0] redirect_pc
);
    import bp_pkg::*;

    logic            dir_wrong;
    logic            target_wrong;
    logic [PC_W-1:0] fall_through;

    assign dir_wrong    = upd_taken_pdc != upd_taken_ex;
    assign target_wrong = upd_taken_pdc && upd_taken_ex && (upd_npc_pdc != upd_npc_ex);

    // next packet after the aligned pair
    assign fall_through = {upd_pc[PC_W-1:1], 1'b0} + PC_W'(2);

    assign mispredict  = update_en && (dir_wrong || target_wrong);
    assign redirect_pc = upd_taken_ex ? upd_npc_ex : fall_through;

endmodule

// ==== bp_pht.sv ====
// pattern history table of 2-bit saturating direction counters
`timescale 1ns/1ps

module bp_pht #(
    parameter int INDEX_W = 6
) (
    input  logic                     clk,
    input  logic                     rstn,
    input  logic                     update_en,
    input  logic [bp_pkg::PC_W-1:0]  upd_pc,
    input  logic                     upd_taken_ex,
    input  logic [bp_pkg::PC_W-1:0]  lookup_pc,
    output logic [bp_pkg::CNT_W-1:0] lookup_cnt
);
    import bp_pkg::*;

    localparam int ENTRIES = 1 << INDEX_W;

    logic [CNT_W-1:0]   cnt [ENTRIES];
    logic [INDEX_W-1:0] upd_idx;
    logic [INDEX_W-1:0] look_idx;
    logic [CNT_W-1:0]   cur;
    logic [CNT_W-1:0]   nxt;

    // packet index, slot bit dropped
    assign upd_idx  = upd_pc[INDEX_W:1];
    assign look_idx = lookup_pc[INDEX_W:1];
    assign cur      = cnt[upd_idx];

    always_comb begin
        nxt = cur;
        if (upd_taken_ex) begin
            if (cur != '1) begin
                nxt = cur + 1'b1;
            end
        end else if (cur != '0) begin
            nxt = cur - 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            for (int i = 0; i < ENTRIES; i++) begin
                cnt[i] <= CNT_INIT;
            end
        end else if (update_en) begin
            cnt[upd_idx] <= nxt;
        end
    end

    assign lookup_cnt = cnt[look_idx];

endmodule

// ==== bp_btb.sv ====
// direct-mapped tagged branch target buffer holding target and kind
`timescale 1ns/1ps

module bp_btb #(
    parameter int INDEX_W = 6,
    parameter int TAG_W   = 8
) (
    input  logic                      clk,
    input  logic                      rstn,
    input  logic                      update_en,
    input  logic [bp_pkg::PC_W-1:0]   upd_pc,
    input  logic                      upd_taken_ex,
    input  logic [bp_pkg::KIND_W-1:0] upd_kind_ex,
    input  logic [bp_pkg::PC_W-1:0]   upd_npc_ex,
    input  logic [bp_pkg::PC_W-1:0]   lookup_pc,
    output logic                      btb_hit,
    output logic [bp_pkg::PC_W-1:0]   pred_target,
    output logic [bp_pkg::KIND_W-1:0] pred_kind
);
    import bp_pkg::*;

    localparam int ENTRIES = 1 << INDEX_W;

    if (INDEX_W + TAG_W + 1 > PC_W) begin : g_width_check
        $error("BTB index and tag do not fit in the pc");
    end

    logic              valid      [ENTRIES];
    logic [TAG_W-1:0]  tag_mem    [ENTRIES];
    logic [PC_W-1:0]   target_mem [ENTRIES];
    logic [KIND_W-1:0] kind_mem   [ENTRIES];

    logic [INDEX_W-1:0] upd_idx;
    logic [TAG_W-1:0]   upd_tag;
    logic [INDEX_W-1:0] look_idx;
    logic [TAG_W-1:0]   look_tag;
    logic               wr_en;

    assign upd_idx  = upd_pc[INDEX_W:1];
    assign upd_tag  = upd_pc[INDEX_W+TAG_W:INDEX_W+1];
    assign look_idx = lookup_pc[INDEX_W:1];
    assign look_tag = lookup_pc[INDEX_W+TAG_W:INDEX_W+1];

    // only taken packets allocate
    assign wr_en = update_en && upd_taken_ex;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            for (int i = 0; i < ENTRIES; i++) begin
                valid[i] <= 1'b0;
            end
        end else if (wr_en) begin
            valid[upd_idx] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en) begin
            tag_mem[upd_idx]    <= upd_tag;
            target_mem[upd_idx] <= upd_npc_ex;
            kind_mem[upd_idx]   <= upd_kind_ex;
        end
    end

    assign btb_hit     = valid[look_idx] && (tag_mem[look_idx] == look_tag);
    assign pred_target = target_mem[look_idx];
    assign pred_kind   = kind_mem[look_idx];

endmodule

// ==== bp_update_top.sv ====
// branch prediction update path with the record queue feeding resolver, pht and btb
`timescale 1ns/1ps

module bp_update_top #(
    parameter int DEPTH   = 4,
    parameter int INDEX_W = 6,
    parameter int TAG_W   = 8
) (
    input  logic                      clk,
    input  logic                      rstn,
    input  logic                      single,
    input  logic                      stall,
    input  logic                      taken_pdc_0,
    input  logic [bp_pkg::KIND_W-1:0] kind_pdc_0,
    input  logic [bp_pkg::PC_W-1:0]   npc_pdc_0,
    input  logic                      taken_ex_0,
    input  logic [bp_pkg::KIND_W-1:0] kind_ex_0,
    input  logic [bp_pkg::PC_W-1:0]   npc_ex_0,
    input  logic [bp_pkg::PC_W-1:0]   pc_ex_0,
    input  logic                      taken_pdc_1,
    input  logic [bp_pkg::KIND_W-1:0] kind_pdc_1,
    input  logic [bp_pkg::PC_W-1:0]   npc_pdc_1,
    input  logic                      taken_ex_1,
    input  logic [bp_pkg::KIND_W-1:0] kind_ex_1,
    input  logic [bp_pkg::PC_W-1:0]   npc_ex_1,
    input  logic [bp_pkg::PC_W-1:0]   pc_ex_1,
    input  logic [bp_pkg::PC_W-1:0]   lookup_pc,
    output logic                      update_en,
    output logic [bp_pkg::KIND_W-1:0] upd_kind_ex,
    output logic                      upd_taken_ex,
    output logic [bp_pkg::PC_W-1:0]   upd_npc_ex,
    output logic                      mispredict,
    output logic [bp_pkg::PC_W-1:0]   redirect_pc,
    output logic                      pred_taken,
    output logic [bp_pkg::PC_W-1:0]   pred_target,
    output logic [bp_pkg::KIND_W-1:0] pred_kind,
    output logic                      btb_hit
);
    import bp_pkg::*;

    logic [PC_W-1:0]  upd_pc;
    logic             upd_taken_pdc;
    logic [PC_W-1:0]  upd_npc_pdc;
    logic [CNT_W-1:0] lookup_cnt;

    ex_buffer #(
        .DEPTH (DEPTH)
    ) u_ex_buffer (
        .clk           (clk),
        .rstn          (rstn),
        .single        (single),
        .stall         (stall),
        .taken_pdc_0   (taken_pdc_0),
        .kind_pdc_0    (kind_pdc_0),
        .npc_pdc_0     (npc_pdc_0),
        .taken_ex_0    (taken_ex_0),
        .kind_ex_0     (kind_ex_0),
        .npc_ex_0      (npc_ex_0),
        .pc_ex_0       (pc_ex_0),
        .taken_pdc_1   (taken_pdc_1),
        .kind_pdc_1    (kind_pdc_1),
        .npc_pdc_1     (npc_pdc_1),
        .taken_ex_1    (taken_ex_1),
        .kind_ex_1     (kind_ex_1),
        .npc_ex_1      (npc_ex_1),
        .pc_ex_1       (pc_ex_1),
        .update_en     (update_en),
        .upd_pc        (upd_pc),
        .upd_taken_pdc (upd_taken_pdc),
        // predicted kind has no consumer without a chooser
        .upd_kind_pdc  (),
        .upd_npc_pdc   (upd_npc_pdc),
        .upd_taken_ex  (upd_taken_ex),
        .upd_kind_ex   (upd_kind_ex),
        .upd_npc_ex    (upd_npc_ex)
    );

    bp_resolve u_resolve (
        .update_en     (update_en),
        .upd_pc        (upd_pc),
        .upd_taken_pdc (upd_taken_pdc),
        .upd_npc_pdc   (upd_npc_pdc),
        .upd_taken_ex  (upd_taken_ex),
        .upd_npc_ex    (upd_npc_ex),
        .mispredict    (mispredict),
        .redirect_pc   (redirect_pc)
    );

    bp_pht #(
        .INDEX_W (INDEX_W)
    ) u_pht (
        .clk          (clk),
        .rstn         (rstn),
        .update_en    (update_en),
        .upd_pc       (upd_pc),
        .upd_taken_ex (upd_taken_ex),
        .lookup_pc    (lookup_pc),
        .lookup_cnt   (lookup_cnt)
    );

    bp_btb #(
        .INDEX_W (INDEX_W),
        .TAG_W   (TAG_W)
    ) u_btb (
        .clk          (clk),
        .rstn         (rstn),
        .update_en    (update_en),
        .upd_pc       (upd_pc),
        .upd_taken_ex (upd_taken_ex),
        .upd_kind_ex  (upd_kind_ex),
        .upd_npc_ex   (upd_npc_ex),
        .lookup_pc    (lookup_pc),
        .btb_hit      (btb_hit),
        .pred_target  (pred_target),
        .pred_kind    (pred_kind)
    );

    // taken only with a known target
    assign pred_taken = btb_hit && lookup_cnt[1];

endmodule

// ==== tb_bp_update.sv ====
// testbench for the branch prediction update path against a reference model
`timescale 1ns/1ps

module tb_bp_update;
    import bp_pkg::*;

    localparam int DEPTH   = 4;
    localparam int INDEX_W = 6;
    localparam int TAG_W   = 8;
    localparam int ENTRIES = 1 << INDEX_W;
    localparam int TIMEOUT = 50;

    typedef struct packed {
        logic              tp;
        logic [KIND_W-1:0] kp;
        logic [PC_W-1:0]   np;
        logic              te;
        logic [KIND_W-1:0] ke;
        logic [PC_W-1:0]   ne;
        logic [PC_W-1:0]   pc;
    } rec_t;

    logic clk;
    logic rstn;
    logic single;
    logic stall;
    logic taken_pdc_0, taken_ex_0, taken_pdc_1, taken_ex_1;
    logic [KIND_W-1:0] kind_pdc_0, kind_ex_0, kind_pdc_1, kind_ex_1;
    logic [PC_W-1:0] npc_pdc_0, npc_ex_0, pc_ex_0, npc_pdc_1, npc_ex_1, pc_ex_1;
    logic [PC_W-1:0] lookup_pc;
    logic update_en, upd_taken_ex, mispredict, pred_taken, btb_hit;
    logic [KIND_W-1:0] upd_kind_ex, pred_kind;
    logic [PC_W-1:0] upd_npc_ex, redirect_pc, pred_target;

    // reference queue and tables
    rec_t              rq [$];
    logic [CNT_W-1:0]  ref_cnt [ENTRIES];
    logic              ref_valid [ENTRIES];
    logic [TAG_W-1:0]  ref_tag [ENTRIES];
    logic [PC_W-1:0]   ref_tgt [ENTRIES];
    logic [KIND_W-1:0] ref_kind [ENTRIES];

    logic              exp_en, exp_te, exp_mis;
    logic [1:0]        exp_pop;
    logic [KIND_W-1:0] exp_ke;
    logic [PC_W-1:0]   exp_pc, exp_ne, exp_redir;
    logic [INDEX_W-1:0] lidx;
    logic              exp_hit, exp_pt;

    int seed = 32'h5f1599b4;
    int errors = 0;
    int mark = 0;
    int tests_ok = 0;
    int tests_bad = 0;

    bp_update_top #(.DEPTH(DEPTH), .INDEX_W(INDEX_W), .TAG_W(TAG_W)) UUT (.*);

    always #10 clk = ~clk;

    function automatic logic [KIND_W-1:0] kind_priority(input logic [KIND_W-1:0] a,
                                                        input logic [KIND_W-1:0] b);
        for (int k = 1; k <= 5; k++) begin
            if (a == KIND_W'(k) || b == KIND_W'(k)) return KIND_W'(k);
        end
        return KIND_NOT_JUMP;
    endfunction

    task automatic compute_expect();
        rec_t h;
        rec_t s;
        exp_en  = 1'b0;
        exp_pop = 2'd0;
        if (rq.size() > 0) begin
            h = rq[0];
            exp_pc = h.pc;
            if (h.pc[0]) begin
                exp_en = 1'b1;
                exp_pop = 2'd1;
                exp_te = h.te;
                exp_ke = h.ke;
                exp_ne = h.ne;
            end else if (rq.size() > 1) begin
                s = rq[1];
                exp_en = 1'b1;
                exp_pop = 2'd2;
                exp_te = h.te | s.te;
                exp_ke = kind_priority(h.ke, s.ke);
                exp_ne = h.te ? h.ne : s.ne;
            end
            exp_mis = exp_en && ((h.tp != exp_te) || (h.tp && exp_te && h.np != exp_ne));
            exp_redir = exp_te ? exp_ne : {exp_pc[PC_W-1:1], 1'b0} + PC_W'(2);
        end else begin
            exp_mis = 1'b0;
        end
    endtask

    // model steps on the same edges as the DUT
    always @(posedge clk) begin : model
        logic [INDEX_W-1:0] idx;
        if (!rstn) begin
            rq.delete();
            for (int i = 0; i < ENTRIES; i++) begin
                ref_cnt[i] = CNT_INIT;
                ref_valid[i] = 1'b0;
            end
        end else begin
            if (exp_en) begin
                idx = exp_pc[INDEX_W:1];
                if (exp_te && ref_cnt[idx] != 2'd3) ref_cnt[idx] = ref_cnt[idx] + 2'd1;
                if (!exp_te && ref_cnt[idx] != 2'd0) ref_cnt[idx] = ref_cnt[idx] - 2'd1;
                if (exp_te) begin
                    ref_valid[idx] = 1'b1;
                    ref_tag[idx] = exp_pc[INDEX_W+TAG_W:INDEX_W+1];
                    ref_tgt[idx] = exp_ne;
                    ref_kind[idx] = exp_ke;
                end
                repeat (exp_pop) void'(rq.pop_front());
            end
            if (!stall) begin
                rq.push_back({taken_pdc_0, kind_pdc_0, npc_pdc_0, taken_ex_0, kind_ex_0,
                              npc_ex_0, pc_ex_0});
                if (!single) begin
                    rq.push_back({taken_pdc_1, kind_pdc_1, npc_pdc_1, taken_ex_1, kind_ex_1,
                                  npc_ex_1, pc_ex_1});
                end
            end
        end
        compute_expect();
    end

    assign lidx    = lookup_pc[INDEX_W:1];
    assign exp_hit = ref_valid[lidx] && ref_tag[lidx] == lookup_pc[INDEX_W+TAG_W:INDEX_W+1];
    assign exp_pt  = exp_hit && ref_cnt[lidx][1];

    a_update_en: assert property (@(posedge clk) disable iff (!rstn) update_en == exp_en)
        else begin
            errors++;
            $display("FAIL update_en got %h expected %h", $sampled(update_en), $sampled(exp_en));
        end

    a_packet: assert property (@(posedge clk) disable iff (!rstn)
        update_en |-> upd_taken_ex == exp_te && upd_kind_ex == exp_ke && upd_npc_ex == exp_ne)
        else begin
            errors++;
            $display("FAIL upd_taken_ex/upd_kind_ex/upd_npc_ex got %h/%h/%h expected %h/%h/%h",
                     $sampled(upd_taken_ex), $sampled(upd_kind_ex), $sampled(upd_npc_ex),
                     $sampled(exp_te), $sampled(exp_ke), $sampled(exp_ne));
        end

    a_mispredict: assert property (@(posedge clk) disable iff (!rstn) mispredict == exp_mis)
        else begin
            errors++;
            $display("FAIL mispredict got %h expected %h", $sampled(mispredict), $sampled(exp_mis));
        end

    a_redirect: assert property (@(posedge clk) disable iff (!rstn)
        update_en |-> redirect_pc == exp_redir)
        else begin
            errors++;
            $display("FAIL redirect_pc got %h expected %h",
                     $sampled(redirect_pc), $sampled(exp_redir));
        end

    a_lookup: assert property (@(posedge clk) disable iff (!rstn)
        btb_hit == exp_hit && pred_taken == exp_pt)
        else begin
            errors++;
            $display("FAIL btb_hit/pred_taken got %h/%h expected %h/%h",
                     $sampled(btb_hit), $sampled(pred_taken), $sampled(exp_hit), $sampled(exp_pt));
        end

    a_target: assert property (@(posedge clk) disable iff (!rstn)
        btb_hit |-> pred_target == ref_tgt[lidx] && pred_kind == ref_kind[lidx])
        else begin
            errors++;
            $display("FAIL pred_target/pred_kind got %h/%h expected %h/%h",
                     $sampled(pred_target), $sampled(pred_kind),
                     $sampled(ref_tgt[lidx]), $sampled(ref_kind[lidx]));
        end

    task automatic random_rec(output rec_t r, input logic [PC_W-1:0] pc);
        logic [31:0] rnd;
        rnd = $random(seed);
        r.tp = rnd[0];
        r.te = rnd[1];
        r.kp = KIND_W'(rnd[7:4] % 6);
        r.ke = KIND_W'(rnd[11:8] % 6);
        rnd = $random(seed);
        r.np = rnd[PC_W-1:0];
        rnd = $random(seed);
        r.ne = r.tp && rnd[31] ? r.np : rnd[PC_W-1:0];
        r.pc = pc;
    endtask

    task automatic drive_rec(input logic stl, input logic sgl, input rec_t a, input rec_t b);
        @(posedge clk);
        stall <= stl;
        single <= sgl;
        {taken_pdc_0, kind_pdc_0, npc_pdc_0, taken_ex_0, kind_ex_0, npc_ex_0, pc_ex_0} <= a;
        {taken_pdc_1, kind_pdc_1, npc_pdc_1, taken_ex_1, kind_ex_1, npc_ex_1, pc_ex_1} <= b;
    endtask

    task automatic hold_stall();
        @(posedge clk);
        stall <= 1'b1;
    endtask

    task automatic report_timeout(input string what);
        errors++;
        $display("timeout while waiting for %s", what);
    endtask

    task automatic wait_update();
        int t;
        t = 0;
        @(negedge clk);
        while (!update_en && t < TIMEOUT) begin
            @(negedge clk);
            t++;
        end
        if (t >= TIMEOUT) report_timeout("update_en");
    endtask

    task automatic wait_drain();
        int t;
        t = 0;
        @(negedge clk);
        while ((rq.size() != 0 || update_en) && t < TIMEOUT) begin
            @(negedge clk);
            t++;
        end
        if (t >= TIMEOUT) report_timeout("the queue to drain");
    endtask

    task automatic end_test(input string name);
        if (errors == mark) begin
            tests_ok++;
            $display("%-32s ok", name);
        end else begin
            tests_bad++;
            $display("%-32s FAILED with %0d errors", name, errors - mark);
        end
        mark = errors;
    endtask

    initial begin
        rec_t r0;
        rec_t r1;
        logic [31:0] rnd;
        logic [PC_W-1:0] pkt;
        clk = 1'b0;
        rstn = 1'b0;
        single = 1'b1;
        stall = 1'b1;
        {taken_pdc_0, kind_pdc_0, npc_pdc_0, taken_ex_0, kind_ex_0, npc_ex_0, pc_ex_0} = '0;
        {taken_pdc_1, kind_pdc_1, npc_pdc_1, taken_ex_1, kind_ex_1, npc_ex_1, pc_ex_1} = '0;
        lookup_pc = '0;
        repeat (4) @(posedge clk);
        rstn <= 1'b1;

        repeat (6) begin
            rnd = $random(seed);
            @(posedge clk);
            lookup_pc <= rnd[PC_W-1:0];
        end
        @(negedge clk);
        end_test("reset state");

        random_rec(r0, 30'h0000_0103);
        drive_rec(1'b0, 1'b1, r0, r0);
        hold_stall();
        wait_update();
        wait_drain();
        end_test("single slot 1 record");

        repeat (2) begin
            rnd = $random(seed);
            pkt = {rnd[PC_W-1:1], 1'b0};
            random_rec(r0, pkt);
            random_rec(r1, pkt | 30'd1);
            drive_rec(1'b0, 1'b1, r0, r0);
            hold_stall();
            repeat (3) @(negedge clk);
            drive_rec(1'b0, 1'b1, r1, r1);
            hold_stall();
            wait_update();
            wait_drain();
        end
        end_test("slot 0 waits for partner");

        for (int i = 0; i < 6; i++) begin
            rnd = $random(seed);
            pkt = {rnd[PC_W-1:1], 1'b0};
            random_rec(r0, pkt);
            random_rec(r1, pkt | 30'd1);
            drive_rec(1'b0, 1'b0, r0, r1);
        end
        hold_stall();
        wait_drain();
        end_test("back to back pairs");

        repeat (8) begin
            random_rec(r0, 30'h0000_0040);
            random_rec(r1, 30'h0000_0041);
            drive_rec(1'b1, 1'b0, r0, r1);
        end
        wait_drain();
        end_test("stall blocks pushes");

        // train one packet taken, then untrain it
        pkt = 30'h0000_2a57;
        r0 = '{tp: 1'b0, kp: KIND_NOT_JUMP, np: '0, te: 1'b1, ke: KIND_CALL,
               ne: 30'h0abc_de00, pc: pkt};
        @(posedge clk);
        lookup_pc <= pkt;
        repeat (3) begin
            drive_rec(1'b0, 1'b1, r0, r0);
            hold_stall();
            wait_drain();
        end
        r0.te = 1'b0;
        repeat (3) begin
            drive_rec(1'b0, 1'b1, r0, r0);
            hold_stall();
            wait_drain();
        end
        end_test("pht and btb training");

        $display("tests ok %0d, tests failed %0d, errors %0d",
                 tests_ok, tests_bad, errors);
        if (errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

// ==== flist.f ====
bp_pkg.sv
ex_buffer.sv
bp_resolve.sv
bp_pht.sv
bp_btb.sv
bp_update_top.sv
tb_bp_update.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_bp_update
RTL_TOP   ?= bp_update_top
FLIST     ?= flist.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert
PASS_MSG  ?= Verification passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(BUILD_DIR)

run: build
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

lint:
	$(VERILATOR) --lint-only --timing --top-module $(RTL_TOP) \
		bp_pkg.sv ex_buffer.sv bp_resolve.sv bp_pht.sv bp_btb.sv bp_update_top.sv

clean:
	rm -rf $(BUILD_DIR)
